//--- opm_reg_top.f
logic/opm_pkg.sv
logic/opm_bus_ctrl.sv
logic/opm_global_regs.sv
logic/opm_chan_regs.sv
logic/opm_reg_top.sv
verification/opm_reg_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the register file testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module opm_reg_tb \
    -Mdir obj_dir \
    -f opm_reg_top.f

./obj_dir/Vopm_reg_tb

//--- verification/opm_reg_tb.sv
`timescale 1ns/1ps

module opm_reg_tb;

    localparam int SYNC_STAGES = 2;
    localparam int BUSY_CYCLES = 32;
    localparam int POLL_LIMIT  = 200;
    localparam int NUM_WRITES  = 200;
    localparam logic [31:0] SEED      = 32'h2ea6;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;   // x^32 + x^22 + x^2 + x + 1

    logic                        i_EMUCLK;
    logic                        mrst_n;
    logic                        i_cs_n;
    logic                        i_wr_n;
    logic                        i_rd_n;
    logic                        i_a0;
    logic [opm_pkg::DATA_W-1:0]  i_d;
    logic                        i_timera_flag;
    logic                        i_timerb_flag;
    logic [opm_pkg::DATA_W-1:0]  o_d;
    logic                        o_d_oe;
    opm_pkg::timer_regs_t        o_timer;
    opm_pkg::lfo_regs_t          o_lfo;
    opm_pkg::noise_regs_t        o_noise;
    opm_pkg::chan_regs_t         o_ch;
    logic [opm_pkg::CH_W-1:0]    o_ch_idx;

    // reference model state
    opm_pkg::timer_regs_t        m_timer;
    opm_pkg::lfo_regs_t          m_lfo;
    opm_pkg::noise_regs_t        m_noise;
    opm_pkg::chan_regs_t         m_ch [opm_pkg::NUM_CH];
    logic [7:0]                  m_addr;       // last address written
    logic                        m_addr_vld;
    int                          exp_frst_a;
    int                          exp_frst_b;
    int                          exp_update;

    int                          cnt_frst_a;
    int                          cnt_frst_b;
    int                          cnt_update;
    logic [31:0]                 lfsr_state;
    string                       cur_test;

    opm_reg_top #(
        .SYNC_STAGES (SYNC_STAGES),
        .BUSY_CYCLES (BUSY_CYCLES)
    ) uut (
        .i_EMUCLK      (i_EMUCLK),
        .mrst_n        (mrst_n),
        .i_cs_n        (i_cs_n),
        .i_wr_n        (i_wr_n),
        .i_rd_n        (i_rd_n),
        .i_a0          (i_a0),
        .i_d           (i_d),
        .o_d           (o_d),
        .o_d_oe        (o_d_oe),
        .i_timera_flag (i_timera_flag),
        .i_timerb_flag (i_timerb_flag),
        .o_timer       (o_timer),
        .o_lfo         (o_lfo),
        .o_noise       (o_noise),
        .o_ch          (o_ch),
        .o_ch_idx      (o_ch_idx)
    );

    always #20 i_EMUCLK = ~i_EMUCLK;

    // pulse counters, sampled mid cycle
    always @(negedge i_EMUCLK) begin
        if (!mrst_n) begin
            cnt_frst_a <= 0;
            cnt_frst_b <= 0;
            cnt_update <= 0;
        end else begin
            if (o_timer.frst_a) cnt_frst_a <= cnt_frst_a + 1;
            if (o_timer.frst_b) cnt_frst_b <= cnt_frst_b + 1;
            if (o_lfo.update)   cnt_update <= cnt_update + 1;
        end
    end

    ////////////////////
    // random source

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // half the time a mapped register, else anything below 0x20
    function automatic logic [7:0] pick_low_addr();
        logic [7:0] a;
        if (take_bits(1) == 32'd1) begin
            case (3'(take_bits(3)))
                3'd0:    a = opm_pkg::LOREG_NOISE;
                3'd1:    a = opm_pkg::LOREG_CLKA1;
                3'd2:    a = opm_pkg::LOREG_CLKA2;
                3'd3:    a = opm_pkg::LOREG_CLKB;
                3'd4:    a = opm_pkg::LOREG_TIMER_CTL;
                3'd5:    a = opm_pkg::LOREG_LFRQ;
                3'd6:    a = opm_pkg::LOREG_PMD_AMD;
                default: a = opm_pkg::LOREG_WAVE;
            endcase
        end else begin
            a = 8'(take_bits(5));
        end
        return a;
    endfunction

    ////////////////////
    // checking

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act == exp) else
            stop_on_error($sformatf("Fail %s, %s: expected 0x%0h, actual 0x%0h",
                                    cur_test, what, exp, act));
    endtask

    task automatic check_globals();
        check_eq("o_timer", 32'(m_timer), 32'(o_timer));
        check_eq("o_lfo", 32'(m_lfo), 32'(o_lfo));
        check_eq("o_noise", 32'(m_noise), 32'(o_noise));
    endtask

    // head of the rotation must match the model, index steps mod 8
    task automatic check_chan_rotation(input int cycles);
        logic [opm_pkg::CH_W-1:0] next_idx;
        int                       n;
        @(negedge i_EMUCLK);
        check_eq("o_ch", 32'(m_ch[o_ch_idx]), 32'(o_ch));
        for (n = 1; n < cycles; n++) begin
            next_idx = o_ch_idx + 3'd1;
            @(negedge i_EMUCLK);
            check_eq("o_ch_idx step", 32'(next_idx), 32'(o_ch_idx));
            check_eq("o_ch", 32'(m_ch[o_ch_idx]), 32'(o_ch));
        end
    endtask

    ////////////////////
    // bus access

    task automatic bus_write(input logic a0, input logic [7:0] d);
        @(posedge i_EMUCLK);
        i_a0   <= a0;
        i_d    <= d;
        i_cs_n <= 1'b0;
        i_wr_n <= 1'b0;
        repeat (2) @(posedge i_EMUCLK);
        i_cs_n <= 1'b1;
        i_wr_n <= 1'b1;
        repeat (SYNC_STAGES + 3) @(posedge i_EMUCLK);   // strobe out, edge detect rearmed
    endtask

    task automatic read_status(input logic fa, input logic fb, output logic [7:0] val);
        @(posedge i_EMUCLK);
        i_cs_n        <= 1'b0;
        i_rd_n        <= 1'b0;
        i_a0          <= 1'b0;
        i_timera_flag <= fa;
        i_timerb_flag <= fb;
        @(negedge i_EMUCLK);
        check_eq("o_d_oe on read", 32'd1, 32'(o_d_oe));
        check_eq("status bits 6:0", 32'({fa, fb}), 32'(o_d[6:0]));
        val = o_d;
        @(posedge i_EMUCLK);
        i_cs_n <= 1'b1;
        i_rd_n <= 1'b1;
    endtask

    task automatic wait_busy_clear();
        logic [7:0] st;
        int         polls;
        read_status(1'(take_bits(1)), 1'(take_bits(1)), st);
        check_eq("busy after data write", 32'd1, 32'(st[7]));
        polls = 0;
        while (st[7]) begin
            if (polls >= POLL_LIMIT) begin
                stop_on_error("Timeout: busy flag still set after 200 status polls");
            end
            read_status(1'(take_bits(1)), 1'(take_bits(1)), st);
            polls++;
        end
    endtask

    ////////////////////
    // model and write sequences

    task automatic model_apply(input logic [7:0] d);
        exp_frst_a = 0;
        exp_frst_b = 0;
        exp_update = 0;
        if (!m_addr_vld) return;
        if (m_addr < 8'h20) begin
            case (m_addr)
                opm_pkg::LOREG_NOISE: begin
                    m_noise.ne   = d[7];
                    m_noise.nfrq = d[4:0];
                end
                opm_pkg::LOREG_CLKA1: m_timer.clka[9:2] = d;
                opm_pkg::LOREG_CLKA2: m_timer.clka[1:0] = d[1:0];
                opm_pkg::LOREG_CLKB:  m_timer.clkb = d;
                opm_pkg::LOREG_TIMER_CTL: begin
                    m_timer.run_a    = d[0];
                    m_timer.run_b    = d[1];
                    m_timer.irq_en_a = d[2];
                    m_timer.irq_en_b = d[3];
                    m_timer.csm      = d[7];
                    exp_frst_a       = int'(d[4]);
                    exp_frst_b       = int'(d[5]);
                end
                opm_pkg::LOREG_LFRQ: begin
                    m_lfo.lfrq = d;
                    exp_update = 1;
                end
                opm_pkg::LOREG_PMD_AMD: begin
                    if (d[7]) m_lfo.pmd = d[6:0];
                    else      m_lfo.amd = d[6:0];
                end
                opm_pkg::LOREG_WAVE: m_lfo.w = d[1:0];
                default: ;  // unmapped low address
            endcase
        end else begin
            case (m_addr[7:3])
                5'h04: begin                        // 0x20 rl/fl/alg
                    m_ch[m_addr[2:0]].rl  = d[7:6];
                    m_ch[m_addr[2:0]].fl  = d[5:3];
                    m_ch[m_addr[2:0]].alg = d[2:0];
                end
                5'h05: m_ch[m_addr[2:0]].kc = d[6:0];
                5'h06: m_ch[m_addr[2:0]].kf = d[7:2];
                default: begin                      // 0x38 pms/ams
                    m_ch[m_addr[2:0]].pms = d[6:4];
                    m_ch[m_addr[2:0]].ams = d[1:0];
                end
            endcase
        end
    endtask

    task automatic write_addr(input logic [7:0] a);
        bus_write(1'b0, a);
        m_addr     = a;
        m_addr_vld = 1'b1;
    endtask

    task automatic write_data(input logic [7:0] d);
        int fa0;
        int fb0;
        int up0;
        fa0 = cnt_frst_a;
        fb0 = cnt_frst_b;
        up0 = cnt_update;
        model_apply(d);
        bus_write(1'b1, d);
        wait_busy_clear();
        check_eq("frst_a pulses", 32'(exp_frst_a), 32'(cnt_frst_a - fa0));
        check_eq("frst_b pulses", 32'(exp_frst_b), 32'(cnt_frst_b - fb0));
        check_eq("update pulses", 32'(exp_update), 32'(cnt_update - up0));
        check_globals();
        check_chan_rotation(opm_pkg::NUM_CH + 2);
    endtask

    ////////////////////
    // main sequence

    initial begin
        logic [7:0] st;
        int         i;

        i_EMUCLK      = 1'b0;
        mrst_n        = 1'b0;
        i_cs_n        = 1'b0;   // read cycle held on the pins during reset
        i_wr_n        = 1'b1;
        i_rd_n        = 1'b0;
        i_a0          = 1'b0;
        i_d           = '0;
        i_timera_flag = 1'b0;
        i_timerb_flag = 1'b0;
        lfsr_state    = SEED;
        m_timer       = '0;
        m_lfo         = '0;
        m_noise       = '0;
        m_addr        = '0;
        m_addr_vld    = 1'b0;
        for (i = 0; i < opm_pkg::NUM_CH; i++) begin
            m_ch[i] = '0;
        end

        cur_test = "reset state";
        repeat (2) @(posedge i_EMUCLK);
        @(negedge i_EMUCLK);
        check_eq("o_d_oe in reset", 32'd0, 32'(o_d_oe));
        @(posedge i_EMUCLK);
        mrst_n <= 1'b1;
        i_cs_n <= 1'b1;
        i_rd_n <= 1'b1;

        @(negedge i_EMUCLK);
        check_globals();
        check_eq("o_d_oe idle", 32'd0, 32'(o_d_oe));
        check_eq("o_ch_idx after reset", 32'd0, 32'(o_ch_idx));
        check_chan_rotation(opm_pkg::NUM_CH);
        read_status(1'b0, 1'b0, st);
        check_eq("status byte", 32'd0, 32'(st));

        cur_test = "busy flag";
        write_addr(opm_pkg::LOREG_CLKB);
        write_data(8'(take_bits(8)));

        cur_test = "global registers";
        for (i = 0; i < NUM_WRITES; i++) begin
            write_addr(pick_low_addr());
            write_data(8'(take_bits(8)));
        end

        cur_test = "pulses";
        for (i = 0; i < 40; i++) begin
            if (take_bits(1) == 32'd1) write_addr(opm_pkg::LOREG_TIMER_CTL);
            else                       write_addr(opm_pkg::LOREG_LFRQ);
            write_data(8'(take_bits(8)));
        end

        cur_test = "channel registers";
        for (i = 0; i < NUM_WRITES; i++) begin
            write_addr(8'h20 | 8'(take_bits(5)));
            write_data(8'(take_bits(8)));
        end

        cur_test = "address retention";
        write_addr(opm_pkg::LOREG_PMD_AMD);
        for (i = 0; i < 4; i++) begin
            write_data(8'(take_bits(8)));
        end
        write_addr(8'h2D);
        for (i = 0; i < 3; i++) begin
            write_data(8'(take_bits(8)));
        end
        // low address in between drops the channel write
        write_addr(8'h2B);
        write_addr(opm_pkg::LOREG_NOISE);
        write_data(8'(take_bits(8)));

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- logic/opm_reg_top.sv
`timescale 1ns/1ps

module opm_reg_top #(
    parameter int SYNC_STAGES = 2,
    parameter int BUSY_CYCLES = 32
) (
    input  logic                          i_EMUCLK,
    input  logic                          mrst_n,

    // cpu bus
    input  logic                          i_cs_n,
    input  logic                          i_wr_n,
    input  logic                          i_rd_n,
    input  logic                          i_a0,
    input  logic [opm_pkg::DATA_W-1:0]    i_d,
    output logic [opm_pkg::DATA_W-1:0]    o_d,
    output logic                          o_d_oe,

    input  logic                          i_timera_flag,
    input  logic                          i_timerb_flag,

    // register outputs
    output opm_pkg::timer_regs_t          o_timer,
    output opm_pkg::lfo_regs_t            o_lfo,
    output opm_pkg::noise_regs_t          o_noise,
    output opm_pkg::chan_regs_t           o_ch,
    output logic [opm_pkg::CH_W-1:0]      o_ch_idx
);

    opm_pkg::bus_wr_t wr;   // strobes to both banks

    opm_bus_ctrl #(
        .SYNC_STAGES (SYNC_STAGES),
        .BUSY_CYCLES (BUSY_CYCLES)
    ) u_bus_ctrl (
        .i_EMUCLK      (i_EMUCLK),
        .mrst_n        (mrst_n),
        .i_cs_n        (i_cs_n),
        .i_wr_n        (i_wr_n),
        .i_rd_n        (i_rd_n),
        .i_a0          (i_a0),
        .i_d           (i_d),
        .i_timera_flag (i_timera_flag),
        .i_timerb_flag (i_timerb_flag),
        .o_wr          (wr),
        .o_d           (o_d),
        .o_d_oe        (o_d_oe)
    );

    opm_global_regs u_global_regs (
        .i_EMUCLK (i_EMUCLK),
        .mrst_n   (mrst_n),
        .i_wr     (wr),
        .o_timer  (o_timer),
        .o_lfo    (o_lfo),
        .o_noise  (o_noise)
    );

    opm_chan_regs u_chan_regs (
        .i_EMUCLK (i_EMUCLK),
        .mrst_n   (mrst_n),
        .i_wr     (wr),
        .o_ch     (o_ch),
        .o_ch_idx (o_ch_idx)
    );

endmodule

//--- logic/opm_chan_regs.sv
`timescale 1ns/1ps

module opm_chan_regs (
    input  logic                          i_EMUCLK,
    input  logic                          mrst_n,

    input  opm_pkg::bus_wr_t              i_wr,

    output opm_pkg::chan_regs_t           o_ch,
    output logic [opm_pkg::CH_W-1:0]      o_ch_idx
);

    localparam logic [opm_pkg::CH_W-1:0] LAST_CH = opm_pkg::CH_W'(opm_pkg::NUM_CH - 1);

    logic [opm_pkg::DATA_W-1:0] pend_addr;
    logic [opm_pkg::DATA_W-1:0] pend_data;
    logic                       pend_addr_vld;
    logic                       pend_data_vld;
    logic                       commit;

    opm_pkg::chan_regs_t        ch_sr [opm_pkg::NUM_CH];   // [0] is the head
    opm_pkg::chan_regs_t        ch_next;

    ////////////////////
    // pending write

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            pend_addr_vld <= 1'b0;
            pend_data_vld <= 1'b0;
        end else if (i_wr.addr_ld) begin
            // a low address cancels the channel write
            pend_addr_vld <= (i_wr.data >= opm_pkg::HIREG_BASE);
            pend_data_vld <= 1'b0;
        end else if (i_wr.data_ld && pend_addr_vld) begin
            pend_data_vld <= 1'b1;
        end else if (commit) begin
            pend_data_vld <= 1'b0;
        end
    end

    always_ff @(posedge i_EMUCLK) begin
        if (i_wr.addr_ld) begin
            pend_addr <= i_wr.data;
        end
        if (i_wr.data_ld && pend_addr_vld) begin
            pend_data <= i_wr.data;
        end
    end

    // wait for the target channel to pass the head
    assign commit = pend_data_vld && (pend_addr[opm_pkg::CH_W-1:0] == o_ch_idx);

    ////////////////////
    // field merge

    always_comb begin
        ch_next = ch_sr[0];
        if (commit) begin
            case (opm_pkg::hireg_group_e'(pend_addr[7:3]))
                opm_pkg::HIREG_RL_FL_ALG: begin
                    ch_next.rl  = pend_data[7:6];
                    ch_next.fl  = pend_data[5:3];
                    ch_next.alg = pend_data[2:0];
                end
                opm_pkg::HIREG_KC:  ch_next.kc = pend_data[6:0];
                opm_pkg::HIREG_KF:  ch_next.kf = pend_data[7:2];
                opm_pkg::HIREG_PMS_AMS: begin
                    ch_next.pms = pend_data[6:4];
                    ch_next.ams = pend_data[1:0];
                end
                default: ;  // operator range, not kept
            endcase
        end
    end

    ////////////////////
    // rotating channel store

    // head goes back in at the tail, counter tracks which channel is at the head
    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            for (int i = 0; i < opm_pkg::NUM_CH; i++) begin
                ch_sr[i] <= '0;
            end
            o_ch_idx <= '0;
        end else begin
            for (int i = 0; i < opm_pkg::NUM_CH - 1; i++) begin
                ch_sr[i] <= ch_sr[i+1];
            end
            ch_sr[opm_pkg::NUM_CH-1] <= ch_next;
            o_ch_idx <= (o_ch_idx == LAST_CH) ? '0 : o_ch_idx + 1'b1;
        end
    end

    assign o_ch = ch_sr[0];

    // accepted data reaches its channel within one rotation
    a_pend_commit: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
        (i_wr.data_ld && pend_addr_vld) |=>
            pend_data_vld ##[1:opm_pkg::NUM_CH] !pend_data_vld);

endmodule

//--- logic/opm_global_regs.sv
`timescale 1ns/1ps

module opm_global_regs (
    input  logic                  i_EMUCLK,
    input  logic                  mrst_n,

    input  opm_pkg::bus_wr_t      i_wr,

    output opm_pkg::timer_regs_t  o_timer,
    output opm_pkg::lfo_regs_t    o_lfo,
    output opm_pkg::noise_regs_t  o_noise
);

    logic [opm_pkg::DATA_W-1:0] lo_addr;   // last low address written
    logic                       lo_valid;
    logic                       wr_en;
    logic [opm_pkg::DATA_W-1:0] wd;

    assign wr_en = i_wr.data_ld & lo_valid;
    assign wd    = i_wr.data;

    ////////////////////
    // address latch

    // a channel address drops the low address until the next one
    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            lo_addr  <= '0;
            lo_valid <= 1'b0;
        end else if (i_wr.addr_ld) begin
            lo_addr  <= i_wr.data;
            lo_valid <= (i_wr.data < opm_pkg::HIREG_BASE);
        end
    end

    ////////////////////
    // register bank

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            o_timer <= '0;
            o_lfo   <= '0;
            o_noise <= '0;
        end else begin
            // pulses drop after one cycle
            o_timer.frst_a <= 1'b0;
            o_timer.frst_b <= 1'b0;
            o_lfo.update   <= 1'b0;

            if (wr_en) begin
                case (opm_pkg::loreg_addr_e'(lo_addr))
                    opm_pkg::LOREG_NOISE: begin
                        o_noise.ne   <= wd[7];
                        o_noise.nfrq <= wd[4:0];
                    end
                    opm_pkg::LOREG_CLKA1:     o_timer.clka[9:2] <= wd;
                    opm_pkg::LOREG_CLKA2:     o_timer.clka[1:0] <= wd[1:0];
                    opm_pkg::LOREG_CLKB:      o_timer.clkb      <= wd;
                    opm_pkg::LOREG_TIMER_CTL: begin
                        o_timer.run_a    <= wd[0];
                        o_timer.run_b    <= wd[1];
                        o_timer.irq_en_a <= wd[2];
                        o_timer.irq_en_b <= wd[3];
                        o_timer.frst_a   <= wd[4];
                        o_timer.frst_b   <= wd[5];
                        o_timer.csm      <= wd[7];  // stored only
                    end
                    opm_pkg::LOREG_LFRQ: begin
                        o_lfo.lfrq   <= wd;
                        o_lfo.update <= 1'b1;       // lfo reloads its rate
                    end
                    opm_pkg::LOREG_PMD_AMD: begin
                        if (wd[7]) begin
                            o_lfo.pmd <= wd[6:0];
                        end else begin
                            o_lfo.amd <= wd[6:0];
                        end
                    end
                    opm_pkg::LOREG_WAVE:      o_lfo.w <= wd[1:0];
                    default: ;                      // unmapped, ignored
                endcase
            end
        end
    end

    a_frst_a_pulse: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
        o_timer.frst_a |=> !o_timer.frst_a);

endmodule

//--- logic/opm_bus_ctrl.sv
`timescale 1ns/1ps

module opm_bus_ctrl #(
    parameter int SYNC_STAGES = 2,     // 2 to 4
    parameter int BUSY_CYCLES = 32     // at least NUM_CH + 2
) (
    input  logic                         i_EMUCLK,
    input  logic                         mrst_n,

    input  logic                         i_cs_n,
    input  logic                         i_wr_n,
    input  logic                         i_rd_n,
    input  logic                         i_a0,
    input  logic [opm_pkg::DATA_W-1:0]   i_d,

    input  logic                         i_timera_flag,
    input  logic                         i_timerb_flag,

    output opm_pkg::bus_wr_t             o_wr,
    output logic [opm_pkg::DATA_W-1:0]   o_d,
    output logic                         o_d_oe
);

    localparam int CNT_W = $clog2(BUSY_CYCLES);

    logic                        wr_act_pin;
    logic [SYNC_STAGES-1:0]      wr_act_sync;
    logic [SYNC_STAGES-1:0]      a0_sync;
    logic [opm_pkg::DATA_W-1:0]  d_sync [SYNC_STAGES];
    logic                        wr_act_q;      // previous synced level
    logic                        wr_rise;

    logic                        addr_ld_q;
    logic                        data_ld_q;
    logic [opm_pkg::DATA_W-1:0]  data_q;

    opm_pkg::busy_state_e        busy_state;
    logic [CNT_W-1:0]            busy_cnt;
    logic                        busy;

    ////////////////////
    // pin synchronizer

    assign wr_act_pin = ~i_cs_n & ~i_wr_n;

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            wr_act_sync <= '0;
            a0_sync     <= '0;
            wr_act_q    <= 1'b0;
        end else begin
            wr_act_sync <= {wr_act_sync[SYNC_STAGES-2:0], wr_act_pin};
            a0_sync     <= {a0_sync[SYNC_STAGES-2:0], i_a0};
            wr_act_q    <= wr_act_sync[SYNC_STAGES-1];
        end
    end

    // data bus follows the same chain depth as the strobes
    always_ff @(posedge i_EMUCLK) begin
        d_sync[0] <= i_d;
        for (int i = 1; i < SYNC_STAGES; i++) begin
            d_sync[i] <= d_sync[i-1];
        end
    end

    ////////////////////
    // write strobes

    assign wr_rise = wr_act_sync[SYNC_STAGES-1] & ~wr_act_q;   // start of a write

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            addr_ld_q <= 1'b0;
            data_ld_q <= 1'b0;
        end else begin
            addr_ld_q <= wr_rise & ~a0_sync[SYNC_STAGES-1];
            data_ld_q <= wr_rise & a0_sync[SYNC_STAGES-1];
        end
    end

    always_ff @(posedge i_EMUCLK) begin
        if (wr_rise) begin
            data_q <= d_sync[SYNC_STAGES-1];
        end
    end

    assign o_wr.addr_ld = addr_ld_q;
    assign o_wr.data_ld = data_ld_q;
    assign o_wr.data    = data_q;

    ////////////////////
    // busy flag

    // each data write (re)starts the busy window
    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            busy_state <= opm_pkg::BUSY_IDLE;
            busy_cnt   <= '0;
        end else if (data_ld_q) begin
            busy_state <= opm_pkg::BUSY_ACTIVE;
            busy_cnt   <= CNT_W'(BUSY_CYCLES - 1);
        end else begin
            case (busy_state)
                opm_pkg::BUSY_ACTIVE: begin
                    if (busy_cnt == '0) begin
                        busy_state <= opm_pkg::BUSY_IDLE;
                    end else begin
                        busy_cnt <= busy_cnt - 1'b1;
                    end
                end
                default: ;  // idle, wait for data_ld
            endcase
        end
    end

    assign busy = (busy_state == opm_pkg::BUSY_ACTIVE);

    ////////////////////
    // status read

    assign o_d    = {busy, 5'b00000, i_timera_flag, i_timerb_flag};
    assign o_d_oe = ~i_cs_n & ~i_rd_n & ~i_a0 & mrst_n;

    // busy holds through the last cycle of the window
    a_busy_window: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
        o_wr.data_ld |=> busy ##(BUSY_CYCLES-1) busy);

endmodule

//--- logic/opm_pkg.sv
package opm_pkg;

    ////////////////////
    // widths and sizes

    parameter int DATA_W = 8;   // cpu bus width
    parameter int NUM_CH = 8;   // fm channels
    parameter int CH_W   = 3;   // channel index width

    // first channel register address, everything below is global
    parameter logic [DATA_W-1:0] HIREG_BASE = 8'h20;

    ////////////////////
    // register maps

    typedef enum logic [7:0] {
        LOREG_NOISE     = 8'h0F,    // ne, nfrq
        LOREG_CLKA1     = 8'h10,    // timer a msbs
        LOREG_CLKA2     = 8'h11,    // timer a lsbs
        LOREG_CLKB      = 8'h12,
        LOREG_TIMER_CTL = 8'h14,
        LOREG_LFRQ      = 8'h18,
        LOREG_PMD_AMD   = 8'h19,    // split by d[7]
        LOREG_WAVE      = 8'h1B
    } loreg_addr_e;

    // address bits 7:3 of the channel register groups
    typedef enum logic [4:0] {
        HIREG_RL_FL_ALG = 5'h04,    // 0x20-0x27
        HIREG_KC        = 5'h05,    // 0x28-0x2f
        HIREG_KF        = 5'h06,    // 0x30-0x37
        HIREG_PMS_AMS   = 5'h07     // 0x38-0x3f
    } hireg_group_e;

    typedef enum logic {
        BUSY_IDLE   = 1'b0,
        BUSY_ACTIVE = 1'b1
    } busy_state_e;

    ////////////////////
    // bundles

    typedef struct packed {
        logic              addr_ld;    // one cycle, a0 low
        logic              data_ld;    // one cycle, a0 high
        logic [DATA_W-1:0] data;
    } bus_wr_t;

    typedef struct packed {
        logic [9:0] clka;
        logic [7:0] clkb;
        logic       run_a;
        logic       run_b;
        logic       irq_en_a;
        logic       irq_en_b;
        logic       csm;
        logic       frst_a;     // pulse
        logic       frst_b;     // pulse
    } timer_regs_t;

    typedef struct packed {
        logic [7:0] lfrq;
        logic [6:0] pmd;
        logic [6:0] amd;
        logic [1:0] w;
        logic       update;     // pulse on 0x18 write
    } lfo_regs_t;

    typedef struct packed {
        logic       ne;
        logic [4:0] nfrq;
    } noise_regs_t;

    typedef struct packed {
        logic [6:0] kc;
        logic [5:0] kf;
        logic [2:0] pms;
        logic [1:0] ams;
        logic [2:0] fl;
        logic [2:0] alg;
        logic [1:0] rl;
    } chan_regs_t;

endpackage
